/* src/uart_pkg.sv */
// uart package: byte, receive entry, divisor, tick and bit index types, state enums
package uart_pkg;

  // one serial data byte
  typedef logic [7:0] uart_byte_t;

  // receive fifo entry, error flag above the data
  typedef struct packed {
    // stop bit sampled low
    logic       frame_error;
    uart_byte_t data;
  } rx_entry_t;

  // clock cycles per oversampling tick, minus one
  typedef logic [15:0] baud_divisor_t;

  // ticks per serial bit
  localparam int OVERSAMPLE = 16;
  // tick index of the bit middle
  localparam int SAMPLE_POINT = 7;

  // tick position inside one bit
  typedef logic [$clog2(OVERSAMPLE)-1:0] tick_count_t;
  // data bit position inside one frame
  typedef logic [2:0] bit_index_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_FETCH,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

/* src/fifo.sv */
// synchronous fifo with watermark full flag and registered pointers
`timescale 1ns/1ns

module fifo #(
  parameter int DATA_SIZE = 8,
  parameter int DEPTH = 8
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     wr_en,
  input  logic                     rd_en,
  input  logic [$clog2(DEPTH)-1:0] watermark_level,
  input  logic [DATA_SIZE-1:0]     wr_data,
  output logic [DATA_SIZE-1:0]     rd_data,
  output logic                     empty,
  output logic                     full
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [DATA_SIZE-1:0] memory [DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  // entries currently held
  logic [PTR_W-1:0]     count;
  logic                 push;
  logic                 pop;

  // full blocks writes, empty blocks reads
  assign push = wr_en && !full;
  assign pop  = rd_en && !empty;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      // one slot behind, so a pop moves it onto the oldest entry
      rd_ptr <= '1;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push with pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      memory[wr_ptr] <= wr_data;
    end
  end

  // last popped entry, held until the next pop
  assign rd_data = memory[rd_ptr];

  assign empty = (count == '0);
  assign full  = (count == watermark_level);

endmodule

/* src/baud_tick_generator.sv */
// oversampling tick generator, one pulse every divisor plus one cycles
`timescale 1ns/1ns

module baud_tick_generator (
  input  logic                    clock,
  input  logic                    reset,
  input  uart_pkg::baud_divisor_t baud_divisor,
  output logic                    tick
);

  // cycles left before the next tick
  uart_pkg::baud_divisor_t count;

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= baud_divisor;
      tick  <= 1'b0;
    end else begin
      if (count == '0) begin
        // reload and pulse for one cycle
        count <= baud_divisor;
        tick  <= 1'b1;
      end else begin
        count <= count - 1'b1;
        tick  <= 1'b0;
      end
    end
  end

endmodule

/* src/uart_transmitter.sv */
// uart transmitter fsm, pops the tx fifo and sends 8N1 frames lsb first
`timescale 1ns/1ns

module uart_transmitter (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 tick,
  input  logic                 fifo_empty,
  input  uart_pkg::uart_byte_t fifo_data,
  output logic                 fifo_read,
  output logic                 serial_out
);

  uart_pkg::tx_state_t   state;
  uart_pkg::tick_count_t tick_count;
  uart_pkg::bit_index_t  bit_index;
  uart_pkg::uart_byte_t  shift;
  // last tick of a start or data bit
  logic                  bit_done;
  // second to last tick of the stop bit
  logic                  stop_done;

  // one pop per frame, rd_data is valid in fetch
  assign fifo_read = (state == uart_pkg::TX_IDLE) && !fifo_empty;

  assign bit_done  = tick && (tick_count == uart_pkg::tick_count_t'(uart_pkg::OVERSAMPLE - 1));
  assign stop_done = tick && (tick_count == uart_pkg::tick_count_t'(uart_pkg::OVERSAMPLE - 2));

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= uart_pkg::TX_IDLE;
      tick_count <= '0;
      bit_index  <= '0;
      serial_out <= 1'b1;
    end else begin
      if (tick) begin
        tick_count <= tick_count + 1'b1;
      end
      case (state)
        uart_pkg::TX_IDLE: begin
          if (!fifo_empty) begin
            state <= uart_pkg::TX_FETCH;
          end
        end
        uart_pkg::TX_FETCH: begin
          // start bit begins on a tick so every bit is whole
          if (tick) begin
            serial_out <= 1'b0;
            tick_count <= '0;
            state      <= uart_pkg::TX_START;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_done) begin
            serial_out <= shift[0];
            bit_index  <= '0;
            state      <= uart_pkg::TX_DATA;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_done) begin
            bit_index <= bit_index + 1'b1;
            if (bit_index == 3'd7) begin
              serial_out <= 1'b1;
              state      <= uart_pkg::TX_STOP;
            end else begin
              serial_out <= shift[0];
            end
          end
        end
        uart_pkg::TX_STOP: begin
          // leave one tick early, idle and fetch use it to chain the next frame
          if (stop_done) begin
            state <= uart_pkg::TX_IDLE;
          end
        end
        default: state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // shift register, next bit always at position 0
  always_ff @(posedge clock) begin
    if (state == uart_pkg::TX_FETCH) begin
      shift <= fifo_data;
    end else if (bit_done && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
      shift <= shift >> 1;
    end
  end

endmodule

/* src/uart_receiver.sv */
// uart receiver fsm, synchronizer, mid-bit sampling, frame error and overrun
`timescale 1ns/1ns

module uart_receiver (
  input  logic                clock,
  input  logic                reset,
  input  logic                tick,
  input  logic                serial_in,
  input  logic                fifo_full,
  output uart_pkg::rx_entry_t entry,
  output logic                entry_write,
  output logic                overrun
);

  logic [1:0]            sync;
  // synchronized serial line
  logic                  line;
  uart_pkg::rx_state_t   state;
  uart_pkg::tick_count_t tick_count;
  uart_pkg::bit_index_t  bit_index;
  uart_pkg::uart_byte_t  data_shift;
  // middle of the start bit
  logic                  start_sample;
  // middle of a data or stop bit
  logic                  bit_sample;

  // two flops against metastability, line idles high
  always_ff @(posedge clock) begin
    if (reset) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], serial_in};
    end
  end

  assign line = sync[1];

  assign start_sample = tick &&
                        (tick_count == uart_pkg::tick_count_t'(uart_pkg::SAMPLE_POINT));
  assign bit_sample   = tick &&
                        (tick_count == uart_pkg::tick_count_t'(uart_pkg::OVERSAMPLE - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= uart_pkg::RX_IDLE;
      tick_count  <= '0;
      bit_index   <= '0;
      entry_write <= 1'b0;
      overrun     <= 1'b0;
    end else begin
      // single cycle pulses
      entry_write <= 1'b0;
      overrun     <= 1'b0;
      if (tick) begin
        tick_count <= tick_count + 1'b1;
      end
      case (state)
        uart_pkg::RX_IDLE: begin
          tick_count <= '0;
          // falling edge, possible start bit
          if (!line) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (start_sample) begin
            tick_count <= '0;
            bit_index  <= '0;
            // high in the middle means a glitch
            state      <= line ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          if (bit_sample) begin
            tick_count <= '0;
            bit_index  <= bit_index + 1'b1;
            if (bit_index == 3'd7) begin
              state <= uart_pkg::RX_STOP;
            end
          end
        end
        uart_pkg::RX_STOP: begin
          if (bit_sample) begin
            state <= uart_pkg::RX_IDLE;
            // no room, byte is lost
            if (fifo_full) begin
              overrun <= 1'b1;
            end else begin
              entry_write <= 1'b1;
            end
          end
        end
        default: state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // data arrives lsb first, shift in from the top
  always_ff @(posedge clock) begin
    if (state == uart_pkg::RX_DATA && bit_sample) begin
      data_shift <= {line, data_shift[7:1]};
    end
    if (state == uart_pkg::RX_STOP && bit_sample) begin
      entry.data        <= data_shift;
      entry.frame_error <= !line;
    end
  end

endmodule

/* src/uart_peripheral.sv */
// uart peripheral top: tx and rx fifos, baud tick generator, transmitter, receiver
`timescale 1ns/1ns

module uart_peripheral #(
  parameter int DEPTH = 8
) (
  input  logic                     clock,
  input  logic                     reset,
  input  uart_pkg::baud_divisor_t  baud_divisor,
  input  logic                     tx_write,
  input  uart_pkg::uart_byte_t     tx_data,
  input  logic [$clog2(DEPTH)-1:0] tx_watermark,
  output logic                     tx_full,
  output logic                     tx_empty,
  input  logic                     rx_read,
  input  logic [$clog2(DEPTH)-1:0] rx_watermark,
  output uart_pkg::rx_entry_t      rx_data,
  output logic                     rx_full,
  output logic                     rx_empty,
  output logic                     rx_overrun,
  input  logic                     serial_in,
  output logic                     serial_out
);

  // shared 16x oversampling tick
  logic                 tick;
  // transmitter side of the tx fifo
  logic                 tx_fifo_read;
  uart_pkg::uart_byte_t tx_fifo_data;
  // receiver side of the rx fifo
  logic                 rx_entry_write;
  uart_pkg::rx_entry_t  rx_entry;

  fifo #(
    .DATA_SIZE($bits(uart_pkg::uart_byte_t)),
    .DEPTH(DEPTH)
  ) tx_fifo (
    .clock(clock),
    .reset(reset),
    .wr_en(tx_write),
    .rd_en(tx_fifo_read),
    .watermark_level(tx_watermark),
    .wr_data(tx_data),
    .rd_data(tx_fifo_data),
    .empty(tx_empty),
    .full(tx_full)
  );

  fifo #(
    .DATA_SIZE($bits(uart_pkg::rx_entry_t)),
    .DEPTH(DEPTH)
  ) rx_fifo (
    .clock(clock),
    .reset(reset),
    .wr_en(rx_entry_write),
    .rd_en(rx_read),
    .watermark_level(rx_watermark),
    .wr_data(rx_entry),
    .rd_data(rx_data),
    .empty(rx_empty),
    .full(rx_full)
  );

  baud_tick_generator baud_tick_generator_inst (
    .clock(clock),
    .reset(reset),
    .baud_divisor(baud_divisor),
    .tick(tick)
  );

  uart_transmitter uart_transmitter_inst (
    .clock(clock),
    .reset(reset),
    .tick(tick),
    .fifo_empty(tx_empty),
    .fifo_data(tx_fifo_data),
    .fifo_read(tx_fifo_read),
    .serial_out(serial_out)
  );

  // overrun decided from the rx fifo full flag
  uart_receiver uart_receiver_inst (
    .clock(clock),
    .reset(reset),
    .tick(tick),
    .serial_in(serial_in),
    .fifo_full(rx_full),
    .entry(rx_entry),
    .entry_write(rx_entry_write),
    .overrun(rx_overrun)
  );

endmodule

/* testbench/uart_peripheral_tb.sv */
// uart peripheral testbench with clock, reset, queue model, serial driver, compare tasks and tests
`timescale 1ns/1ns

module uart_peripheral_tb;

  localparam int DEPTH = 8;
  localparam int WM_BITS = $clog2(DEPTH);
  // divisor 1 gives one tick every 2 cycles
  localparam int BIT_CYCLES = uart_pkg::OVERSAMPLE * 2;
  localparam int TIMEOUT_CYCLES = 2000;

  typedef logic [WM_BITS-1:0] watermark_t;

  logic                    clock;
  logic                    reset;
  uart_pkg::baud_divisor_t baud_divisor;
  logic                    tx_write;
  uart_pkg::uart_byte_t    tx_data;
  watermark_t              tx_watermark;
  logic                    tx_full;
  logic                    tx_empty;
  logic                    rx_read;
  watermark_t              rx_watermark;
  uart_pkg::rx_entry_t     rx_data;
  logic                    rx_full;
  logic                    rx_empty;
  logic                    rx_overrun;
  logic                    serial_out;
  // serial_in source select
  logic                    loopback;
  logic                    bang_line;
  logic                    serial_line;

  // predicted rx fifo contents in arrival order
  uart_pkg::rx_entry_t expected[$];
  int                  expected_drops = 0;
  int                  overrun_count = 0;

  assign serial_line = loopback ? serial_out : bang_line;

  uart_peripheral #(
    .DEPTH(DEPTH)
  ) uart_peripheral_inst (
    .clock(clock),
    .reset(reset),
    .baud_divisor(baud_divisor),
    .tx_write(tx_write),
    .tx_data(tx_data),
    .tx_watermark(tx_watermark),
    .tx_full(tx_full),
    .tx_empty(tx_empty),
    .rx_read(rx_read),
    .rx_watermark(rx_watermark),
    .rx_data(rx_data),
    .rx_full(rx_full),
    .rx_empty(rx_empty),
    .rx_overrun(rx_overrun),
    .serial_in(serial_line),
    .serial_out(serial_out)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // count one-cycle overrun pulses at mid cycle
  always @(negedge clock) begin
    if (!reset && rx_overrun) begin
      overrun_count++;
    end
  end

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on error");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    abort_run();
  endtask

  task automatic check_entry(input string name, input uart_pkg::rx_entry_t want,
                             input uart_pkg::rx_entry_t got);
    if (got !== want) begin
      $display("FAILED %s: expected %h, actual %h", name, want, got);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input uart_pkg::uart_byte_t want,
                            input uart_pkg::uart_byte_t got);
    if (got !== want) begin
      $display("FAILED %s: expected %h, actual %h", name, want, got);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic want, input logic got);
    if (got !== want) begin
      $display("FAILED %s: expected %b, actual %b", name, want, got);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int want, input int got);
    if (got != want) begin
      $display("FAILED %s: expected %0d, actual %0d", name, want, got);
      abort_run();
    end
  endtask

  task automatic wait_rx_data(input string what);
    int cycles;
    cycles = 0;
    while (rx_empty) begin
      @(negedge clock);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_timeout(what);
      end
    end
  endtask

  task automatic wait_tx_space();
    int cycles;
    cycles = 0;
    while (tx_full) begin
      @(negedge clock);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_timeout("tx_full to fall");
      end
    end
  endtask

  task automatic wait_tx_idle(input string what);
    int cycles;
    cycles = 0;
    while (!tx_empty) begin
      @(negedge clock);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_timeout(what);
      end
    end
  endtask

  // one-cycle strobes started on a falling edge
  task automatic write_byte(input uart_pkg::uart_byte_t value);
    tx_write = 1'b1;
    tx_data  = value;
    @(negedge clock);
    tx_write = 1'b0;
  endtask

  task automatic pop_entry();
    rx_read = 1'b1;
    @(negedge clock);
    rx_read = 1'b0;
  endtask

  // bit-banged frame would land in the rx fifo unless it is at the watermark
  task automatic model_receive(input uart_pkg::rx_entry_t entry);
    if (expected.size() >= int'(rx_watermark)) begin
      expected_drops++;
    end else begin
      expected.push_back(entry);
    end
  endtask

  task automatic read_and_check(input string name);
    uart_pkg::rx_entry_t want;
    wait_rx_data({name, " entry to arrive"});
    if (expected.size() == 0) begin
      $display("%s: an entry arrived that the model did not predict", name);
      abort_run();
    end
    want = expected.pop_front();
    pop_entry();
    // popped entry is visible the cycle after the pop
    check_entry(name, want, rx_data);
  endtask

  task automatic write_stream(input int count);
    uart_pkg::uart_byte_t value;
    for (int i = 0; i < count; i++) begin
      wait_tx_space();
      value = uart_pkg::uart_byte_t'($urandom);
      write_byte(value);
      expected.push_back('{frame_error: 1'b0, data: value});
    end
  endtask

  task automatic read_stream(input int count, input string name);
    for (int i = 0; i < count; i++) begin
      read_and_check(name);
    end
  endtask

  // start bit, 8 data bits lsb first, stop bit and one idle bit
  task automatic send_frame(input uart_pkg::uart_byte_t value, input logic stop);
    bang_line = 1'b0;
    repeat (BIT_CYCLES) @(negedge clock);
    for (int i = 0; i < 8; i++) begin
      bang_line = value[i];
      repeat (BIT_CYCLES) @(negedge clock);
    end
    // stop level held past the sample point and released before a false start is rechecked
    bang_line = stop;
    repeat (BIT_CYCLES * 3 / 4) @(negedge clock);
    bang_line = 1'b1;
    repeat (BIT_CYCLES / 4 + BIT_CYCLES) @(negedge clock);
  endtask

  initial begin
    int                   base;
    int                   wm;
    int                   accepted;
    uart_pkg::uart_byte_t value;
    uart_pkg::rx_entry_t  last;

    void'($urandom(56));
    reset        = 1'b1;
    baud_divisor = uart_pkg::baud_divisor_t'(1);
    tx_write     = 1'b0;
    tx_data      = '0;
    tx_watermark = watermark_t'(DEPTH - 1);
    rx_read      = 1'b0;
    rx_watermark = watermark_t'(DEPTH - 1);
    loopback     = 1'b1;
    bang_line    = 1'b1;
    repeat (3) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    // state right after reset
    check_flag("reset tx_empty", 1'b1, tx_empty);
    check_flag("reset rx_empty", 1'b1, rx_empty);
    check_flag("reset tx_full", 1'b0, tx_full);
    check_flag("reset rx_full", 1'b0, rx_full);
    check_flag("reset rx_overrun", 1'b0, rx_overrun);
    check_flag("reset serial_out", 1'b1, serial_out);

    // loopback with writer and reader side by side
    base = overrun_count;
    fork
      write_stream(20);
      read_stream(20, "loopback order");
    join
    check_count("loopback overruns", 0, overrun_count - base);

    // watermark full with one frame on the wire
    wm = $urandom_range(DEPTH - 1, 1);
    tx_watermark = watermark_t'(wm);
    value = uart_pkg::uart_byte_t'($urandom);
    write_byte(value);
    expected.push_back('{frame_error: 1'b0, data: value});
    wait_tx_idle("transmitter to pop the first byte");
    accepted = 0;
    while (!tx_full) begin
      value = uart_pkg::uart_byte_t'($urandom);
      write_byte(value);
      expected.push_back('{frame_error: 1'b0, data: value});
      accepted++;
      if (accepted > DEPTH) begin
        $display("tx_full never rose after %0d accepted writes", accepted);
        abort_run();
      end
    end
    // transmitter is busy, so the fifo fills exactly up to the watermark
    check_count("writes accepted up to watermark", wm, accepted);
    // writes while full are dropped
    for (int i = 0; i < 3; i++) begin
      check_flag("tx_full before extra write", 1'b1, tx_full);
      write_byte(uart_pkg::uart_byte_t'($urandom));
    end
    read_stream(expected.size(), "watermark order");
    repeat (2 * 11 * BIT_CYCLES) @(negedge clock);
    check_flag("rx_empty after watermark drain", 1'b1, rx_empty);
    check_flag("tx_empty after watermark drain", 1'b1, tx_empty);
    tx_watermark = watermark_t'(DEPTH - 1);

    // frame error from a low stop bit
    loopback = 1'b0;
    value = uart_pkg::uart_byte_t'($urandom);
    send_frame(value, 1'b0);
    model_receive('{frame_error: 1'b1, data: value});
    wait_rx_data("frame error entry to arrive");
    last = expected.pop_front();
    pop_entry();
    check_byte("frame error data", last.data, rx_data.data);
    check_flag("frame error flag", last.frame_error, rx_data.frame_error);
    check_flag("rx_empty after frame error", 1'b1, rx_empty);

    // overrun with a watermark of 2 and no reads
    rx_watermark = watermark_t'(2);
    base = overrun_count;
    expected_drops = 0;
    for (int i = 0; i < 3; i++) begin
      value = uart_pkg::uart_byte_t'($urandom);
      send_frame(value, 1'b1);
      model_receive('{frame_error: 1'b0, data: value});
      check_flag("rx_full after frame", (expected.size() >= 2), rx_full);
    end
    check_count("overrun pulses", expected_drops, overrun_count - base);
    read_stream(expected.size(), "overrun survivors");
    check_flag("rx_empty after overrun drain", 1'b1, rx_empty);
    // pop on empty leaves the last entry in place
    last = rx_data;
    pop_entry();
    check_entry("read while empty", last, rx_data);
    check_flag("rx_empty after empty read", 1'b1, rx_empty);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* uart_peripheral.f */
src/uart_pkg.sv
src/fifo.sv
src/baud_tick_generator.sv
src/uart_transmitter.sv
src/uart_receiver.sv
src/uart_peripheral.sv
testbench/uart_peripheral_tb.sv

/* Makefile */
# Verilator build for the uart peripheral and its testbench

VERILATOR       ?= verilator
FILELIST        ?= uart_peripheral.f
RTL_TOP         ?= uart_peripheral
TB_TOP          ?= uart_peripheral_tb
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?=
PASS_TEXT       ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VERILATOR_FLAGS) \
		--top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing $(VERILATOR_FLAGS) \
		--top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	$(BUILD_DIR)/$(TB_TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
